/* Bender.yml */
package:
  name: rob

sources:
  - rob_pkg.sv
  - rob_cdb_if.sv
  - rob_regfile.sv
  - rob_ptr_ctrl.sv
  - rob_complete_table.sv
  - rob.sv
  - rob_top.sv
  - target: test
    files:
      - rob_top_assert.sv
      - tb_rob.sv

/* build.f */
rob_pkg.sv
rob_cdb_if.sv
rob_regfile.sv
rob_ptr_ctrl.sv
rob_complete_table.sv
rob.sv
rob_top.sv
rob_top_assert.sv
tb_rob.sv

/* rob.sv */
`timescale 1ns/1ps

module rob
    import rob_pkg::*;
#(
    parameter int ROB_WIDTH = 4
) (
    input  logic                           clk,
    input  logic                           rst_i,
    input  logic                           flush_i,
    input  logic [1:0]                     dispatch_i,
    input  logic [1:0][ROB_WIDTH-1:0]      dispatch_id_i,
    input  rob_inst_entry_t [1:0]          dispatch_entry_i,
    rob_cdb_if.sink                        cdb,
    input  logic [3:0][ROB_WIDTH-1:0]      src_id_i,
    output logic [3:0][XLEN-1:0]           src_data_o,
    output logic [3:0]                     src_ready_o,
    input  logic [1:0]                     commit_req_i,
    output logic [1:0]                     commit_valid_o,
    output logic [1:0][AREG_WIDTH-1:0]     commit_areg_o,
    output logic [1:0]                     commit_w_reg_o,
    output logic [1:0][XLEN-1:0]           commit_pc_o,
    output logic [1:0][XLEN-1:0]           commit_wdata_o,
    output logic [1:0]                     commit_exc_o,
    output logic [1:0][EXC_CODE_WIDTH-1:0] commit_exc_code_o,
    output logic [1:0][BADVA_WIDTH-1:0]    commit_badva_o,
    output logic                           rob_space_o
);

logic [ROB_WIDTH-1:0]  head_ptr0;
logic [ROB_WIDTH-1:0]  head_ptr1;
logic [ROB_WIDTH:0]    count;
logic [1:0]            head_done;
rob_inst_entry_t [1:0] inst_rd;
rob_data_entry_t [5:0] data_rd;
rob_data_entry_t [1:0] cdb_wdata;

rob_ptr_ctrl #(
    .ROB_WIDTH (ROB_WIDTH)
) u_ptr_ctrl (
    .clk          (clk),
    .rst_i        (rst_i),
    .flush_i      (flush_i),
    .dispatch_i   (dispatch_i),
    .commit_req_i (commit_req_i),
    .head_ptr0_o  (head_ptr0),
    .head_ptr1_o  (head_ptr1),
    .count_o      (count),
    .rob_space_o  (rob_space_o)
);

rob_complete_table #(
    .ROB_WIDTH (ROB_WIDTH)
) u_complete_table (
    .clk           (clk),
    .dispatch_i    (dispatch_i),
    .dispatch_id_i (dispatch_id_i),
    .cdb           (cdb),
    .head_ptr0_i   (head_ptr0),
    .head_ptr1_i   (head_ptr1),
    .src_id_i      (src_id_i),
    .head_done_o   (head_done),
    .src_done_o    (src_ready_o)
);

////////////////////////////////////////
// instruction and data tables
////////////////////////////////////////

rob_regfile #(
    .DATA_WIDTH ($bits(rob_inst_entry_t)),
    .ROB_WIDTH  (ROB_WIDTH),
    .R_PORTS    (2),
    .W_PORTS    (2)
) u_inst_table (
    .clk     (clk),
    .raddr_i ({head_ptr1, head_ptr0}),
    .rdata_o (inst_rd),
    .we_i    (dispatch_i),
    .waddr_i (dispatch_id_i),
    .wdata_i (dispatch_entry_i)
);

always_comb begin
    for (int i = 0; i < 2; i++) begin
        cdb_wdata[i].result = cdb.result[i];
        cdb_wdata[i].exc    = cdb.exc[i];
    end
end

// heads on ports 0..1, sources on 2..5
rob_regfile #(
    .DATA_WIDTH ($bits(rob_data_entry_t)),
    .ROB_WIDTH  (ROB_WIDTH),
    .R_PORTS    (6),
    .W_PORTS    (2)
) u_data_table (
    .clk     (clk),
    .raddr_i ({src_id_i, head_ptr1, head_ptr0}),
    .rdata_o (data_rd),
    .we_i    (cdb.valid),
    .waddr_i (cdb.id),
    .wdata_i (cdb_wdata)
);

always_comb begin
    for (int s = 0; s < 4; s++) begin
        src_data_o[s] = data_rd[s + 2].result.data;
    end
end

////////////////////////////////////////
// commit
////////////////////////////////////////

// lane 1 only behind lane 0
assign commit_valid_o[0] = head_done[0] && (count > 0);
assign commit_valid_o[1] = commit_valid_o[0] && head_done[1] && (count > 1);

always_comb begin
    for (int i = 0; i < 2; i++) begin
        commit_areg_o[i]  = inst_rd[i].areg;
        commit_w_reg_o[i] = inst_rd[i].w_reg;
        commit_pc_o[i]    = inst_rd[i].pc;
        commit_exc_o[i]   = data_rd[i].exc;
        // union decode, flag picks the view
        if (data_rd[i].exc) begin
            commit_wdata_o[i]    = '0;
            commit_exc_code_o[i] = data_rd[i].result.exc.code;
            commit_badva_o[i]    = data_rd[i].result.exc.badva;
        end else begin
            commit_wdata_o[i]    = data_rd[i].result.data;
            commit_exc_code_o[i] = '0;
            commit_badva_o[i]    = '0;
        end
    end
end

endmodule

/* rob_cdb_if.sv */
`timescale 1ns/1ps

interface rob_cdb_if
    import rob_pkg::*;
#(
    parameter int ROB_WIDTH = 4
) ();

// two lanes, one pulse per completing entry
logic [1:0]                valid;
logic [1:0][ROB_WIDTH-1:0] id;
rob_result_u [1:0]         result;
logic [1:0]                exc;

// driven from the top level ports
modport source (
    output valid, id, result, exc
);

// buffer side
modport sink (
    input valid, id, result, exc
);

endinterface

/* rob_complete_table.sv */
`timescale 1ns/1ps

module rob_complete_table #(
    parameter int ROB_WIDTH = 4
) (
    input  logic                      clk,
    input  logic [1:0]                dispatch_i,
    input  logic [1:0][ROB_WIDTH-1:0] dispatch_id_i,
    rob_cdb_if.sink                   cdb,
    input  logic [ROB_WIDTH-1:0]      head_ptr0_i,
    input  logic [ROB_WIDTH-1:0]      head_ptr1_i,
    input  logic [3:0][ROB_WIDTH-1:0] src_id_i,
    output logic [1:0]                head_done_o,
    output logic [3:0]                src_done_o
);

// read port map, same for both tables
// 0..1 heads, 2..5 sources, 6..7 the other side's write indices
logic [7:0][ROB_WIDTH-1:0] disp_raddr;
logic [7:0][ROB_WIDTH-1:0] cdb_raddr;
logic [7:0]                disp_bit;
logic [7:0]                cdb_bit;
logic [1:0]                disp_wdata;
logic [1:0]                cdb_wdata;
logic [5:0]                done;

assign disp_raddr = {cdb.id, src_id_i, head_ptr1_i, head_ptr0_i};
assign cdb_raddr  = {dispatch_id_i, src_id_i, head_ptr1_i, head_ptr0_i};

////////////////////////////////////////
// parity tables
////////////////////////////////////////

// dispatch copies the cdb bit, so the pair reads equal (not done)
assign disp_wdata = cdb_bit[7:6];

// cdb flips against the dispatch bit, so the pair differs (done)
assign cdb_wdata = ~disp_bit[7:6];

rob_regfile #(
    .DATA_WIDTH (1),
    .ROB_WIDTH  (ROB_WIDTH),
    .R_PORTS    (8),
    .W_PORTS    (2)
) u_disp_table (
    .clk     (clk),
    .raddr_i (disp_raddr),
    .rdata_o (disp_bit),
    .we_i    (dispatch_i),
    .waddr_i (dispatch_id_i),
    .wdata_i (disp_wdata)
);

rob_regfile #(
    .DATA_WIDTH (1),
    .ROB_WIDTH  (ROB_WIDTH),
    .R_PORTS    (8),
    .W_PORTS    (2)
) u_cdb_table (
    .clk     (clk),
    .raddr_i (cdb_raddr),
    .rdata_o (cdb_bit),
    .we_i    (cdb.valid),
    .waddr_i (cdb.id),
    .wdata_i (cdb_wdata)
);

// done when the two bits disagree
assign done        = disp_bit[5:0] ^ cdb_bit[5:0];
assign head_done_o = done[1:0];
assign src_done_o  = done[5:2];

endmodule

/* rob_pkg.sv */
package rob_pkg;

////////////////////////////////////////
// widths
////////////////////////////////////////

localparam int XLEN           = 32;
localparam int AREG_WIDTH     = 5;
localparam int EXC_CODE_WIDTH = 6;
localparam int BADVA_WIDTH    = 26;

////////////////////////////////////////
// table entries
////////////////////////////////////////

// written at dispatch, read back at commit
typedef struct packed {
    logic [AREG_WIDTH-1:0] areg;
    logic                  w_reg;
    logic [XLEN-1:0]       pc;
} rob_inst_entry_t;

// exception view of a result word
typedef struct packed {
    logic [EXC_CODE_WIDTH-1:0] code;
    logic [BADVA_WIDTH-1:0]    badva;
} rob_exc_view_t;

// one result word, two decodings
// the exception flag next to it picks the view
typedef union packed {
    logic [XLEN-1:0] data;
    rob_exc_view_t   exc;
} rob_result_u;

// written on a cdb strobe
typedef struct packed {
    rob_result_u result;
    logic        exc;
} rob_data_entry_t;

endpackage

/* rob_ptr_ctrl.sv */
`timescale 1ns/1ps

module rob_ptr_ctrl #(
    parameter int ROB_WIDTH = 4
) (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 flush_i,
    input  logic [1:0]           dispatch_i,
    input  logic [1:0]           commit_req_i,
    output logic [ROB_WIDTH-1:0] head_ptr0_o,
    output logic [ROB_WIDTH-1:0] head_ptr1_o,
    output logic [ROB_WIDTH:0]   count_o,
    output logic                 rob_space_o
);

localparam logic [ROB_WIDTH:0] DEPTH = (ROB_WIDTH + 1)'(1 << ROB_WIDTH);

logic [1:0]           n_dispatch;
logic [1:0]           n_commit;
logic [ROB_WIDTH-1:0] head_ptr0_q;
logic [ROB_WIDTH-1:0] head_ptr1_q;
logic [ROB_WIDTH:0]   count_q;
logic [ROB_WIDTH:0]   free_cnt;

assign n_dispatch = {1'b0, dispatch_i[0]} + {1'b0, dispatch_i[1]};
assign n_commit   = {1'b0, commit_req_i[0]} + {1'b0, commit_req_i[1]};

// flush behaves like reset for the pointers and the count
always_ff @(posedge clk) begin
    if (rst_i || flush_i) begin
        head_ptr0_q <= '0;
        head_ptr1_q <= ROB_WIDTH'(1);
        count_q     <= '0;
    end else begin
        head_ptr0_q <= head_ptr0_q + ROB_WIDTH'(n_commit);
        head_ptr1_q <= head_ptr1_q + ROB_WIDTH'(n_commit);
        count_q     <= count_q + (ROB_WIDTH + 1)'(n_dispatch) - (ROB_WIDTH + 1)'(n_commit);
    end
end

// room for a full dispatch pair
assign free_cnt    = DEPTH - count_q;
assign rob_space_o = free_cnt >= (ROB_WIDTH + 1)'(2);

assign head_ptr0_o = head_ptr0_q;
assign head_ptr1_o = head_ptr1_q;
assign count_o     = count_q;

endmodule

/* rob_regfile.sv */
`timescale 1ns/1ps

module rob_regfile #(
    parameter int DATA_WIDTH = 32,
    parameter int ROB_WIDTH  = 4,
    parameter int R_PORTS    = 2,
    parameter int W_PORTS    = 2
) (
    input  logic                               clk,
    input  logic [R_PORTS-1:0][ROB_WIDTH-1:0]  raddr_i,
    output logic [R_PORTS-1:0][DATA_WIDTH-1:0] rdata_o,
    input  logic [W_PORTS-1:0]                 we_i,
    input  logic [W_PORTS-1:0][ROB_WIDTH-1:0]  waddr_i,
    input  logic [W_PORTS-1:0][DATA_WIDTH-1:0] wdata_i
);

localparam int DEPTH = 1 << ROB_WIDTH;

logic [DATA_WIDTH-1:0] mem_q [DEPTH];

////////////////////////////////////////
// write side
////////////////////////////////////////

// ports in rising order, so the highest enabled port lands last
always_ff @(posedge clk) begin
    for (int w = 0; w < W_PORTS; w++) begin
        if (we_i[w]) begin
            mem_q[waddr_i[w]] <= wdata_i[w];
        end
    end
end

////////////////////////////////////////
// read side
////////////////////////////////////////

// no bypass, a same-cycle write shows up next cycle
always_comb begin
    for (int r = 0; r < R_PORTS; r++) begin
        rdata_o[r] = mem_q[raddr_i[r]];
    end
end

endmodule

/* rob_top.sv */
`timescale 1ns/1ps

module rob_top
    import rob_pkg::*;
#(
    parameter int ROB_WIDTH = 4
) (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        flush_i,
    input  logic [1:0]                  dispatch_i,
    input  logic [2*ROB_WIDTH-1:0]      dispatch_id_i,
    input  logic [2*AREG_WIDTH-1:0]     dispatch_areg_i,
    input  logic [1:0]                  dispatch_w_reg_i,
    input  logic [2*XLEN-1:0]           dispatch_pc_i,
    input  logic [1:0]                  cdb_valid_i,
    input  logic [2*ROB_WIDTH-1:0]      cdb_id_i,
    input  logic [2*XLEN-1:0]           cdb_result_i,
    input  logic [1:0]                  cdb_exc_i,
    input  logic [4*ROB_WIDTH-1:0]      src_id_i,
    output logic [4*XLEN-1:0]           src_data_o,
    output logic [3:0]                  src_ready_o,
    input  logic [1:0]                  commit_req_i,
    output logic [1:0]                  commit_valid_o,
    output logic [2*AREG_WIDTH-1:0]     commit_areg_o,
    output logic [1:0]                  commit_w_reg_o,
    output logic [2*XLEN-1:0]           commit_pc_o,
    output logic [2*XLEN-1:0]           commit_wdata_o,
    output logic [1:0]                  commit_exc_o,
    output logic [2*EXC_CODE_WIDTH-1:0] commit_exc_code_o,
    output logic [2*BADVA_WIDTH-1:0]    commit_badva_o,
    output logic                        rob_space_o
);

rob_inst_entry_t [1:0] dispatch_entry;

rob_cdb_if #(.ROB_WIDTH(ROB_WIDTH)) cdb_bus ();

// cdb ports onto the bus, lane 0 in the low bits
assign cdb_bus.valid  = cdb_valid_i;
assign cdb_bus.id     = cdb_id_i;
assign cdb_bus.result = cdb_result_i;
assign cdb_bus.exc    = cdb_exc_i;

always_comb begin
    for (int i = 0; i < 2; i++) begin
        dispatch_entry[i].areg  = dispatch_areg_i[i*AREG_WIDTH +: AREG_WIDTH];
        dispatch_entry[i].w_reg = dispatch_w_reg_i[i];
        dispatch_entry[i].pc    = dispatch_pc_i[i*XLEN +: XLEN];
    end
end

rob #(
    .ROB_WIDTH (ROB_WIDTH)
) u_rob (
    .clk               (clk),
    .rst_i             (rst_i),
    .flush_i           (flush_i),
    .dispatch_i        (dispatch_i),
    .dispatch_id_i     (dispatch_id_i),
    .dispatch_entry_i  (dispatch_entry),
    .cdb               (cdb_bus.sink),
    .src_id_i          (src_id_i),
    .src_data_o        (src_data_o),
    .src_ready_o       (src_ready_o),
    .commit_req_i      (commit_req_i),
    .commit_valid_o    (commit_valid_o),
    .commit_areg_o     (commit_areg_o),
    .commit_w_reg_o    (commit_w_reg_o),
    .commit_pc_o       (commit_pc_o),
    .commit_wdata_o    (commit_wdata_o),
    .commit_exc_o      (commit_exc_o),
    .commit_exc_code_o (commit_exc_code_o),
    .commit_badva_o    (commit_badva_o),
    .rob_space_o       (rob_space_o)
);

endmodule

/* rob_top_assert.sv */
`timescale 1ns/1ps

module rob_top_assert #(
    parameter int ROB_WIDTH = 4
) (
    input logic               clk,
    input logic               rst_i,
    input logic               flush_i,
    input logic [1:0]         dispatch_i,
    input logic [1:0]         commit_req_i,
    input logic [ROB_WIDTH:0] count_o,
    input logic               rob_space_o
);

localparam int DEPTH = 1 << ROB_WIDTH;

int fail_cnt = 0;

// occupancy never beyond the buffer
count_in_range: assert property (@(posedge clk) disable iff (rst_i)
    count_o <= DEPTH)
    else begin
        $error("occupancy count above depth");
        fail_cnt++;
    end

// dispatch needs room for a pair
dispatch_has_space: assert property (@(posedge clk) disable iff (rst_i || flush_i)
    (dispatch_i != 2'b00) |-> rob_space_o)
    else begin
        $error("dispatch while the buffer has no space");
        fail_cnt++;
    end

commit_within_count: assert property (@(posedge clk) disable iff (rst_i || flush_i)
    $countones(commit_req_i) <= count_o)
    else begin
        $error("commit request beyond occupancy");
        fail_cnt++;
    end

endmodule

bind rob_ptr_ctrl rob_top_assert #(.ROB_WIDTH(ROB_WIDTH)) u_assert (
    .clk          (clk),
    .rst_i        (rst_i),
    .flush_i      (flush_i),
    .dispatch_i   (dispatch_i),
    .commit_req_i (commit_req_i),
    .count_o      (count_o),
    .rob_space_o  (rob_space_o)
);

/* tb_rob.sv */
`timescale 1ns/1ps

module tb_rob
    import rob_pkg::*;
();

localparam int ROB_WIDTH  = 4;
localparam int DEPTH      = 1 << ROB_WIDTH;
localparam int N_ROWS     = 16;
localparam int TOTAL_ROWS = 42;
localparam int CLK_PERIOD = 10;

logic                        clk;
logic                        rst_i;
logic                        flush_i;
logic [1:0]                  dispatch_i;
logic [2*ROB_WIDTH-1:0]      dispatch_id_i;
logic [2*AREG_WIDTH-1:0]     dispatch_areg_i;
logic [1:0]                  dispatch_w_reg_i;
logic [2*XLEN-1:0]           dispatch_pc_i;
logic [1:0]                  cdb_valid_i;
logic [2*ROB_WIDTH-1:0]      cdb_id_i;
logic [2*XLEN-1:0]           cdb_result_i;
logic [1:0]                  cdb_exc_i;
logic [4*ROB_WIDTH-1:0]      src_id_i;
logic [4*XLEN-1:0]           src_data_o;
logic [3:0]                  src_ready_o;
logic [1:0]                  commit_req_i;
logic [1:0]                  commit_valid_o;
logic [2*AREG_WIDTH-1:0]     commit_areg_o;
logic [1:0]                  commit_w_reg_o;
logic [2*XLEN-1:0]           commit_pc_o;
logic [2*XLEN-1:0]           commit_wdata_o;
logic [1:0]                  commit_exc_o;
logic [2*EXC_CODE_WIDTH-1:0] commit_exc_code_o;
logic [2*BADVA_WIDTH-1:0]    commit_badva_o;
logic                        rob_space_o;

// stimulus table, one row per instruction
logic [AREG_WIDTH-1:0] t_areg [N_ROWS];
logic                  t_wreg [N_ROWS];
logic [XLEN-1:0]       t_pc   [N_ROWS];
logic [XLEN-1:0]       t_word [N_ROWS];
logic                  t_exc  [N_ROWS];
int                    t_rank [N_ROWS];

logic        done_q [N_ROWS];
logic [15:0] lfsr_q = 16'd59251;
int          checks = 0;
int          errors = 0;

rob_top #(.ROB_WIDTH(ROB_WIDTH)) dut (.*);

initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
end

// worst case is about 40 cycles per row
initial begin
    #((TOTAL_ROWS * 40 + 200) * CLK_PERIOD);
    $display("watchdog expired before all tests finished");
    $display("Test FAILED");
    $finish;
end

////////////////////////////////////////
// helpers
////////////////////////////////////////

task automatic set_row(input int i, input logic [AREG_WIDTH-1:0] areg, input logic w_reg,
                       input logic [XLEN-1:0] pc, input logic [XLEN-1:0] word,
                       input logic exc, input int rank);
    t_areg[i] = areg;
    t_wreg[i] = w_reg;
    t_pc[i]   = pc;
    t_word[i] = word;
    t_exc[i]  = exc;
    t_rank[i] = rank;
endtask

// 16-bit galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

task automatic draw_bit(output logic b);
    b      = lfsr_q[0];
    lfsr_q = lfsr_next(lfsr_q);
endtask

task automatic check_value(input string what, input logic [XLEN-1:0] got,
                           input logic [XLEN-1:0] exp);
    checks++;
    assert (got === exp) else begin
        errors++;
        $display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
endtask

// exception rows carry the code in the top bits, the address below
task automatic check_lane(input int l, input int row);
    logic [XLEN-1:0] word;
    logic            exc;
    word = t_word[row];
    exc  = t_exc[row];
    check_value($sformatf("lane %0d areg", l), commit_areg_o[l*AREG_WIDTH +: AREG_WIDTH],
                t_areg[row]);
    check_value($sformatf("lane %0d w_reg", l), commit_w_reg_o[l], t_wreg[row]);
    check_value($sformatf("lane %0d pc", l), commit_pc_o[l*XLEN +: XLEN], t_pc[row]);
    check_value($sformatf("lane %0d exc", l), commit_exc_o[l], exc);
    check_value($sformatf("lane %0d wdata", l), commit_wdata_o[l*XLEN +: XLEN],
                exc ? '0 : word);
    check_value($sformatf("lane %0d exc code", l),
                commit_exc_code_o[l*EXC_CODE_WIDTH +: EXC_CODE_WIDTH],
                exc ? word[XLEN-1 -: EXC_CODE_WIDTH] : '0);
    check_value($sformatf("lane %0d badva", l), commit_badva_o[l*BADVA_WIDTH +: BADVA_WIDTH],
                exc ? word[BADVA_WIDTH-1:0] : '0);
endtask

// nothing retired yet, so the head is row 0 of the batch
task automatic check_heads(input int n);
    logic v0;
    logic v1;
    v0 = done_q[0];
    v1 = v0 && (n > 1) && done_q[1];
    check_value("commit valid", commit_valid_o, {v1, v0});
    if (v0) begin
        check_lane(0, 0);
    end
endtask

// port s reads row (row + s) of the batch
task automatic check_sources(input int row, input int n);
    int j;
    for (int s = 0; s < 4; s++) begin
        j = (row + s) % n;
        check_value($sformatf("source %0d ready", s), src_ready_o[s], done_q[j]);
        if (done_q[j]) begin
            check_value($sformatf("source %0d data", s), src_data_o[s*XLEN +: XLEN],
                        t_word[j]);
        end
    end
endtask

task automatic drive_pair(input int row, input int idx);
    dispatch_i       <= 2'b11;
    dispatch_id_i    <= {ROB_WIDTH'((idx + 1) % DEPTH), ROB_WIDTH'(idx % DEPTH)};
    dispatch_areg_i  <= {t_areg[row + 1], t_areg[row]};
    dispatch_w_reg_i <= {t_wreg[row + 1], t_wreg[row]};
    dispatch_pc_i    <= {t_pc[row + 1], t_pc[row]};
endtask

task automatic report_test(input string name, input int errs_before);
    $display("%-24s %s", name, (errors == errs_before) ? "pass" : "fail");
endtask

////////////////////////////////////////
// one batch: dispatch, cdb by rank, commit
////////////////////////////////////////

task automatic run_batch(input int n, input int base);
    int                     row;
    int                     idx;
    int                     committed;
    logic                   b0;
    logic                   b1;
    logic [1:0]             req;
    logic [4*ROB_WIDTH-1:0] src_ids;
    for (int i = 0; i < n; i += 2) begin
        @(posedge clk);
        drive_pair(i, base + i);
        @(negedge clk);
        check_value("space at dispatch", rob_space_o, 1'b1);
    end
    @(posedge clk);
    dispatch_i <= 2'b00;
    @(negedge clk);
    check_value("space after dispatch", rob_space_o, (DEPTH - n) >= 2);
    for (int i = 0; i < N_ROWS; i++) begin
        done_q[i] = 1'b0;
    end
    for (int r = 0; r < N_ROWS; r++) begin
        row = N_ROWS;
        for (int k = 0; k < N_ROWS; k++) begin
            if (t_rank[k] == r) begin
                row = k;
            end
        end
        if (row < n) begin
            idx = (base + row) % DEPTH;
            for (int s = 0; s < 4; s++) begin
                src_ids[s*ROB_WIDTH +: ROB_WIDTH] = ROB_WIDTH'((base + (row + s) % n) % DEPTH);
            end
            @(posedge clk);
            src_id_i <= src_ids;
            @(negedge clk);
            check_sources(row, n);
            check_heads(n);
            // lane picked by rank parity
            @(posedge clk);
            cdb_valid_i  <= 2'(1 << (r % 2));
            cdb_id_i     <= {2{ROB_WIDTH'(idx)}};
            cdb_result_i <= {2{t_word[row]}};
            cdb_exc_i    <= {2{t_exc[row]}};
            @(posedge clk);
            cdb_valid_i <= 2'b00;
            done_q[row] = 1'b1;
            @(negedge clk);
            check_sources(row, n);
            check_heads(n);
        end
    end
    // random commit pattern, a zero request holds the head
    committed = 0;
    while (committed < n) begin
        @(negedge clk);
        check_value("commit valid", commit_valid_o, {(n - committed) > 1, 1'b1});
        check_lane(0, committed);
        if ((n - committed) > 1) begin
            check_lane(1, committed + 1);
        end
        draw_bit(b0);
        draw_bit(b1);
        req = {b0 && b1 && ((n - committed) > 1), b0};
        @(posedge clk);
        commit_req_i <= req;
        @(posedge clk);
        commit_req_i <= 2'b00;
        committed += req[0] + req[1];
    end
    @(negedge clk);
    check_value("commit valid when empty", commit_valid_o, 2'b00);
    check_value("space when empty", rob_space_o, 1'b1);
endtask

////////////////////////////////////////
// main sequence
////////////////////////////////////////

initial begin
    int errs;
    int assert_fails;
    rst_i            = 1'b1;
    flush_i          = 1'b0;
    dispatch_i       = '0;
    dispatch_id_i    = '0;
    dispatch_areg_i  = '0;
    dispatch_w_reg_i = '0;
    dispatch_pc_i    = '0;
    cdb_valid_i      = '0;
    cdb_id_i         = '0;
    cdb_result_i     = '0;
    cdb_exc_i        = '0;
    src_id_i         = '0;
    commit_req_i     = '0;
    // completion tables have no reset, seed both halves equal
    for (int i = 0; i < DEPTH; i++) begin
        dut.u_rob.u_complete_table.u_disp_table.mem_q[i] = ^i;
        dut.u_rob.u_complete_table.u_cdb_table.mem_q[i]  = ^i;
    end
    set_row(0,  5'd1,  1'b1, 32'h0000_1000, 32'h1234_0001, 1'b0, 5);
    set_row(1,  5'd2,  1'b1, 32'h0000_1004, 32'h2345_0002, 1'b0, 12);
    set_row(2,  5'd3,  1'b1, 32'h0000_1008, 32'h3456_0003, 1'b0, 0);
    set_row(3,  5'd4,  1'b0, 32'h0000_100C, 32'hAC00_3F10, 1'b1, 9);
    set_row(4,  5'd5,  1'b1, 32'h0000_1010, 32'h4567_0005, 1'b0, 3);
    set_row(5,  5'd6,  1'b0, 32'h0000_1014, 32'h5678_0006, 1'b0, 14);
    set_row(6,  5'd7,  1'b1, 32'h0000_1018, 32'h6789_0007, 1'b0, 7);
    set_row(7,  5'd8,  1'b1, 32'h0000_101C, 32'h789A_0008, 1'b0, 1);
    set_row(8,  5'd9,  1'b1, 32'h0000_1020, 32'h3400_0A24, 1'b1, 10);
    set_row(9,  5'd10, 1'b1, 32'h0000_1024, 32'h89AB_000A, 1'b0, 15);
    set_row(10, 5'd11, 1'b0, 32'h0000_1028, 32'h9ABC_000B, 1'b0, 2);
    set_row(11, 5'd12, 1'b1, 32'h0000_102C, 32'hABCD_000C, 1'b0, 8);
    set_row(12, 5'd13, 1'b1, 32'h0000_1030, 32'hBCDE_000D, 1'b0, 13);
    set_row(13, 5'd14, 1'b1, 32'h0000_1034, 32'hFC12_3456, 1'b1, 4);
    set_row(14, 5'd15, 1'b1, 32'h0000_1038, 32'hCDEF_000F, 1'b0, 11);
    set_row(15, 5'd31, 1'b1, 32'h0000_103C, 32'hDEF0_0010, 1'b0, 6);
    repeat (5) @(posedge clk);
    rst_i <= 1'b0;

    errs = errors;
    run_batch(10, 0);
    report_test("in-order retirement", errs);

    // a full buffer, indices 10..15 then 0..9
    errs = errors;
    run_batch(16, 10);
    report_test("wrap-around and full", errs);

    // four pending at 10..13, the first two done, then flush
    errs = errors;
    @(posedge clk);
    drive_pair(0, 10);
    @(posedge clk);
    drive_pair(2, 12);
    @(posedge clk);
    dispatch_i   <= 2'b00;
    cdb_valid_i  <= 2'b11;
    cdb_id_i     <= {ROB_WIDTH'(11), ROB_WIDTH'(10)};
    cdb_result_i <= {t_word[1], t_word[0]};
    cdb_exc_i    <= {t_exc[1], t_exc[0]};
    @(posedge clk);
    cdb_valid_i <= 2'b00;
    @(negedge clk);
    check_value("commit valid before flush", commit_valid_o, 2'b11);
    @(posedge clk);
    flush_i <= 1'b1;
    @(posedge clk);
    flush_i <= 1'b0;
    @(negedge clk);
    check_value("commit valid after flush", commit_valid_o, 2'b00);
    check_value("space after flush", rob_space_o, 1'b1);
    report_test("flush", errs);

    // covers indices 10 and 11, done before the flush
    errs = errors;
    run_batch(12, 0);
    report_test("redispatch after flush", errs);

    assert_fails = dut.u_rob.u_ptr_ctrl.u_assert.fail_cnt;
    if (assert_fails != 0) begin
        $display("protocol assertions failed %0d times", assert_fails);
        errors += assert_fails;
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
        $display("Test OK");
    end else begin
        $display("Test FAILED");
    end
    $finish;
end

endmodule
